//--- hw/isaPkg.sv
package isaPkg;

    ////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        OR  = 4'h3,
        XOR = 4'h4,
        NOR = 4'h5,
        SLT = 4'h6,
        SLL = 4'h7,
        SRL = 4'h8,
        SRA = 4'h9,
        LUI = 4'hA
    } aluOpE;

    // R-type funct field, low 6 bits of the instruction
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_ADD  = 6'h20,
        FN_SUB  = 6'h22,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2A
    } functE;

    // Immediate opcodes as they arrive on immOpcode
    typedef enum logic [6:0] {
        IMM_ADDI = 7'h08,
        IMM_SLTI = 7'h0A,
        IMM_ANDI = 7'h0C,
        IMM_ORI  = 7'h0D,
        IMM_XORI = 7'h0E,
        IMM_LUI  = 7'h0F
    } immOpE;

    ////////////////////////////////////////
    // aluOp field of the execute control
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        MODE_ADD   = 2'b00,  // load and store address
        MODE_SUB   = 2'b01,  // beq compare
        MODE_RTYPE = 2'b10,
        MODE_IMM   = 2'b11
    } aluModeE;

endpackage

//--- hw/pipePkg.sv
package pipePkg;

    ////////////////////////////////////////
    // Control field widths and bit positions
    ////////////////////////////////////////

    // Writeback field, bit 0 is regWrite
    localparam int WB_W  = 5;

    localparam int MEM_W = 3;
    localparam int MEM_BRANCH = 2;

    // Execute field holds regDst, aluMode and aluSrc
    localparam int EXE_W = 4;
    localparam int EXE_REGDST = 3;
    localparam int EXE_MODE_LSB = 1;
    localparam int EXE_ALUSRC = 0;

    localparam int REG_W = 5;

    // Shamt position inside the extended immediate
    localparam int SHAMT_W = 5;
    localparam int SHAMT_LSB = 6;

    // Operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwdSelE;

endpackage

//--- hw/aluControl.sv
`timescale 1ns/1ps

module aluControl
    import isaPkg::*;
    import pipePkg::*;
(
    input  aluModeE              aluMode,
    input  logic [5:0]           funct,
    input  logic [6:0]           immOpcode,
    input  logic [SHAMT_W-1:0]   shamt,
    output aluOpE                aluSel,
    output logic                 shiftImm
);

    aluOpE rtypeSel;
    aluOpE immSel;
    logic  fixedShift;

    // R-type decode
    always_comb
    begin
        case (functE'(funct))
            FN_ADD:  rtypeSel = ADD;
            FN_SUB:  rtypeSel = SUB;
            FN_AND:  rtypeSel = AND;
            FN_OR:   rtypeSel = OR;
            FN_XOR:  rtypeSel = XOR;
            FN_NOR:  rtypeSel = NOR;
            FN_SLT:  rtypeSel = SLT;
            FN_SLL,
            FN_SLLV: rtypeSel = SLL;
            FN_SRL,
            FN_SRLV: rtypeSel = SRL;
            FN_SRA,
            FN_SRAV: rtypeSel = SRA;
            default: rtypeSel = ADD;
        endcase
    end

    // Immediate decode
    always_comb
    begin
        case (immOpE'(immOpcode))
            IMM_ADDI: immSel = ADD;
            IMM_ANDI: immSel = AND;
            IMM_ORI:  immSel = OR;
            IMM_XORI: immSel = XOR;
            IMM_SLTI: immSel = SLT;
            IMM_LUI:  immSel = LUI;
            default:  immSel = ADD;
        endcase
    end

    always_comb
    begin
        case (aluMode)
            MODE_ADD:   aluSel = ADD;
            MODE_SUB:   aluSel = SUB;
            MODE_RTYPE: aluSel = rtypeSel;
            MODE_IMM:   aluSel = immSel;
            default:    aluSel = ADD;
        endcase
    end

    // Fixed shifts take shamt only when it is nonzero
    assign fixedShift = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);
    assign shiftImm = (aluMode == MODE_RTYPE) && fixedShift && (shamt != '0);

    always_comb
    begin
        if (!$isunknown(aluMode))
        begin
            assert final (!$isunknown(aluSel))
            else $error("aluControl: aluSel unknown with aluMode %b", aluMode);
        end
    end

endmodule

//--- hw/forwardingUnit.sv
`timescale 1ns/1ps

module forwardingUnit
    import pipePkg::*;
(
    input  logic [REG_W-1:0] rs,
    input  logic [REG_W-1:0] rt,
    input  logic [REG_W-1:0] memRd,
    input  logic [REG_W-1:0] wbRd,
    input  logic             memRegWrite,
    input  logic             wbRegWrite,
    output fwdSelE           fwdSelA,
    output fwdSelE           fwdSelB
);

    logic memHitA;
    logic memHitB;
    logic wbHitA;
    logic wbHitB;

    // Register zero is hardwired and never forwarded
    assign memHitA = memRegWrite && (rs != '0) && (rs == memRd);
    assign memHitB = memRegWrite && (rt != '0) && (rt == memRd);
    assign wbHitA  = wbRegWrite && (rs != '0) && (rs == wbRd);
    assign wbHitB  = wbRegWrite && (rt != '0) && (rt == wbRd);

    // MEM holds the younger value so it wins
    assign fwdSelA = memHitA ? FWD_MEM : (wbHitA ? FWD_WB : FWD_NONE);
    assign fwdSelB = memHitB ? FWD_MEM : (wbHitB ? FWD_WB : FWD_NONE);

    always_comb
    begin
        assert final (fwdSelA != 2'b11 && fwdSelB != 2'b11)
        else $error("forwardingUnit: unused select code A=%b B=%b", fwdSelA, fwdSelB);
    end

endmodule

//--- hw/operandSelect.sv
`timescale 1ns/1ps

module operandSelect
    import pipePkg::*;
#(
    parameter int dataWidth = 32
)
(
    input  logic [dataWidth-1:0] regA,
    input  logic [dataWidth-1:0] regB,
    input  logic [dataWidth-1:0] immExt,
    input  logic [dataWidth-1:0] memAluResult,
    input  logic [dataWidth-1:0] wbData,
    input  fwdSelE               fwdSelA,
    input  fwdSelE               fwdSelB,
    input  logic                 shiftImm,
    input  logic                 aluSrc,
    output logic [dataWidth-1:0] aluA,
    output logic [dataWidth-1:0] aluB
);

    logic [dataWidth-1:0] fwdA;
    logic [dataWidth-1:0] fwdB;
    logic [dataWidth-1:0] shamtExt;

    ////////////////////////////////////////
    // Forwarding muxes
    ////////////////////////////////////////
    always_comb
    begin
        case (fwdSelA)
            FWD_MEM: fwdA = memAluResult;
            FWD_WB:  fwdA = wbData;
            default: fwdA = regA;
        endcase
        case (fwdSelB)
            FWD_MEM: fwdB = memAluResult;
            FWD_WB:  fwdB = wbData;
            default: fwdB = regB;
        endcase
    end

    // Shamt field, zero extended
    assign shamtExt = {{(dataWidth-SHAMT_W){1'b0}}, immExt[SHAMT_LSB +: SHAMT_W]};

    assign aluA = shiftImm ? shamtExt : fwdA;
    assign aluB = aluSrc ? immExt : fwdB;

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu
    import isaPkg::*;
#(
    parameter int dataWidth = 32
)
(
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  aluOpE                sel,
    output logic [dataWidth-1:0] result,
    output logic                 zero
);

    localparam int SHIFT_W = $clog2(dataWidth);
    localparam int HALF = dataWidth / 2;

    logic [SHIFT_W-1:0] shiftAmt;

    // Shift count from the low bits of a
    assign shiftAmt = a[SHIFT_W-1:0];

    always_comb
    begin
        case (sel)
            ADD: result = a + b;
            SUB: result = a - b;
            AND: result = a & b;
            OR:  result = a | b;
            XOR: result = a ^ b;
            NOR: result = ~(a | b);
            SLT:
            begin
                result = '0;
                result[0] = $signed(a) < $signed(b);
            end
            SLL: result = b << shiftAmt;
            SRL: result = b >> shiftAmt;
            SRA: result = $signed(b) >>> shiftAmt;
            // Lower half of b moves up over a cleared low half
            LUI: result = {b[HALF-1:0], {HALF{1'b0}}};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- hw/exMemRegister.sv
`timescale 1ns/1ps

module exMemRegister
    import pipePkg::*;
#(
    parameter int dataWidth = 32
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic [WB_W-1:0]      wbCtrl,
    input  logic [MEM_W-1:0]     memCtrl,
    input  logic                 regDst,
    input  logic [REG_W-1:0]     rt,
    input  logic [REG_W-1:0]     rd,
    input  logic [dataWidth-1:0] aluResult,
    input  logic                 aluZero,
    input  logic [dataWidth-1:0] regB,
    output logic [WB_W-1:0]      outWb,
    output logic [MEM_W-1:0]     outMem,
    output logic [dataWidth-1:0] outAluResult,
    output logic                 outAluZero,
    output logic [dataWidth-1:0] outRegB,
    output logic [REG_W-1:0]     outDestReg
);

    logic [REG_W-1:0] destReg;

    // R-type writes rd, loads and immediates write rt
    assign destReg = regDst ? rd : rt;

    ////////////////////////////////////////
    // EX/MEM boundary
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outWb        <= '0;
            outMem       <= '0;
            outAluResult <= '0;
            outAluZero   <= 1'b0;
            outRegB      <= '0;
            outDestReg   <= '0;
        end
        else if (!stall)
        begin
            outWb        <= wbCtrl;
            outMem       <= memCtrl;
            outAluResult <= aluResult;
            outAluZero   <= aluZero;
            outRegB      <= regB;
            outDestReg   <= destReg;
        end
    end

    // Debug stall freezes the whole boundary
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable({outWb, outMem, outAluResult, outAluZero, outRegB, outDestReg}))
    else $error("exMemRegister: outputs changed after a stall cycle");

endmodule

//--- hw/executeStage.sv
`timescale 1ns/1ps

module executeStage
    import isaPkg::*;
    import pipePkg::*;
#(
    parameter int dataWidth = 32
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [WB_W-1:0]      wbCtrl,
    input  logic [MEM_W-1:0]     memCtrl,
    input  logic [EXE_W-1:0]     exeCtrl,
    input  logic [dataWidth-1:0] pcNext,
    input  logic [dataWidth-1:0] regA,
    input  logic [dataWidth-1:0] regB,
    input  logic [dataWidth-1:0] immExt,
    input  logic [REG_W-1:0]     rs,
    input  logic [REG_W-1:0]     rt,
    input  logic [REG_W-1:0]     rd,
    input  logic [6:0]           immOpcode,
    input  logic [dataWidth-1:0] memAluResult,
    input  logic [REG_W-1:0]     memRd,
    input  logic                 memRegWrite,
    input  logic [dataWidth-1:0] wbData,
    input  logic [REG_W-1:0]     wbRd,
    input  logic                 wbRegWrite,
    input  logic                 stall,
    output logic                 pcSel,
    output logic [dataWidth-1:0] pcJump,
    output logic [WB_W-1:0]      outWb,
    output logic [MEM_W-1:0]     outMem,
    output logic [dataWidth-1:0] outAluResult,
    output logic                 outAluZero,
    output logic [dataWidth-1:0] outRegB,
    output logic [REG_W-1:0]     outDestReg
);

    aluModeE              aluMode;
    aluOpE                aluSel;
    fwdSelE               fwdSelA;
    fwdSelE               fwdSelB;
    logic                 shiftImm;
    logic [dataWidth-1:0] aluA;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic                 aluZero;

    assign aluMode = aluModeE'(exeCtrl[EXE_MODE_LSB +: 2]);

    ////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////

    // Immediate arrives already scaled
    assign pcJump = pcNext + immExt;
    // Raw operands here, not the forwarded ones
    assign pcSel = memCtrl[MEM_BRANCH] && (regA == regB);

    aluControl aluControl0 (
        .aluMode   (aluMode),
        .funct     (immExt[5:0]),
        .immOpcode (immOpcode),
        .shamt     (immExt[SHAMT_LSB +: SHAMT_W]),
        .aluSel    (aluSel),
        .shiftImm  (shiftImm)
    );

    forwardingUnit forwardingUnit0 (
        .rs          (rs),
        .rt          (rt),
        .memRd       (memRd),
        .wbRd        (wbRd),
        .memRegWrite (memRegWrite),
        .wbRegWrite  (wbRegWrite),
        .fwdSelA     (fwdSelA),
        .fwdSelB     (fwdSelB)
    );

    operandSelect #(.dataWidth(dataWidth)) operandSelect0 (
        .regA         (regA),
        .regB         (regB),
        .immExt       (immExt),
        .memAluResult (memAluResult),
        .wbData       (wbData),
        .fwdSelA      (fwdSelA),
        .fwdSelB      (fwdSelB),
        .shiftImm     (shiftImm),
        .aluSrc       (exeCtrl[EXE_ALUSRC]),
        .aluA         (aluA),
        .aluB         (aluB)
    );

    alu #(.dataWidth(dataWidth)) alu0 (
        .a      (aluA),
        .b      (aluB),
        .sel    (aluSel),
        .result (aluResult),
        .zero   (aluZero)
    );

    exMemRegister #(.dataWidth(dataWidth)) exMemRegister0 (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .wbCtrl       (wbCtrl),
        .memCtrl      (memCtrl),
        .regDst       (exeCtrl[EXE_REGDST]),
        .rt           (rt),
        .rd           (rd),
        .aluResult    (aluResult),
        .aluZero      (aluZero),
        .regB         (regB),
        .outWb        (outWb),
        .outMem       (outMem),
        .outAluResult (outAluResult),
        .outAluZero   (outAluZero),
        .outRegB      (outRegB),
        .outDestReg   (outDestReg)
    );

endmodule

//--- testbench/tbExecuteStage.sv
`timescale 1ns/1ps

module tbExecuteStage
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int dataWidth = 32;
    localparam int vectorsPerTest = 200;
    // Reset plus 6 tests of 200 vectors and some margin
    localparam int cycleLimit = 1500;

    logic                 clk;
    logic                 rst;
    logic                 stall;
    logic [WB_W-1:0]      wbCtrl;
    logic [MEM_W-1:0]     memCtrl;
    logic [EXE_W-1:0]     exeCtrl;
    logic [dataWidth-1:0] pcNext;
    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] immExt;
    logic [REG_W-1:0]     rs;
    logic [REG_W-1:0]     rt;
    logic [REG_W-1:0]     rd;
    logic [6:0]           immOpcode;
    logic [dataWidth-1:0] memAluResult;
    logic [REG_W-1:0]     memRd;
    logic                 memRegWrite;
    logic [dataWidth-1:0] wbData;
    logic [REG_W-1:0]     wbRd;
    logic                 wbRegWrite;
    logic                 pcSel;
    logic [dataWidth-1:0] pcJump;
    logic [WB_W-1:0]      outWb;
    logic [MEM_W-1:0]     outMem;
    logic [dataWidth-1:0] outAluResult;
    logic                 outAluZero;
    logic [dataWidth-1:0] outRegB;
    logic [REG_W-1:0]     outDestReg;

    // Expected EX/MEM contents after the latest edge
    logic [WB_W-1:0]      expWb;
    logic [MEM_W-1:0]     expMem;
    logic [dataWidth-1:0] expResult;
    logic                 expZero;
    logic [dataWidth-1:0] expRegB;
    logic [REG_W-1:0]     expDest;

    logic [31:0] lfsrState;
    string       testName;
    int          testErrors;
    int          totalErrors;
    int          checkCount;
    int          cycleCount;

    functE rtypeList [7] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT};
    functE shiftList [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    immOpE immList [6] = '{IMM_ADDI, IMM_ANDI, IMM_ORI, IMM_XORI, IMM_SLTI, IMM_LUI};

    executeStage #(.dataWidth(dataWidth)) DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("timeout: run stopped after %0d cycles before the tests finished",
                cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Random numbers and reference model
    ////////////////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic aluOpE modelOp(input logic [1:0] mode, input logic [5:0] fn,
                                      input logic [6:0] immOp);
        if (mode == MODE_ADD)
            return ADD;
        if (mode == MODE_SUB)
            return SUB;
        if (mode == MODE_RTYPE)
        begin
            case (fn)
                FN_SUB: return SUB;
                FN_AND: return AND;
                FN_OR:  return OR;
                FN_XOR: return XOR;
                FN_NOR: return NOR;
                FN_SLT: return SLT;
                FN_SLL, FN_SLLV: return SLL;
                FN_SRL, FN_SRLV: return SRL;
                FN_SRA, FN_SRAV: return SRA;
                default: return ADD;
            endcase
        end
        case (immOp)
            IMM_ANDI: return AND;
            IMM_ORI:  return OR;
            IMM_XORI: return XOR;
            IMM_SLTI: return SLT;
            IMM_LUI:  return LUI;
            default:  return ADD;
        endcase
    endfunction

    function automatic logic [31:0] modelAlu(input aluOpE op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            SUB: return a - b;
            AND: return a & b;
            OR:  return a | b;
            XOR: return a ^ b;
            NOR: return ~(a | b);
            SLT: return {31'b0, $signed(a) < $signed(b)};
            SLL: return b << a[4:0];
            SRL: return b >> a[4:0];
            SRA: return $signed(b) >>> a[4:0];
            LUI: return {b[15:0], 16'h0000};
            default: return a + b;
        endcase
    endfunction

    // MEM before WB and never register zero
    function automatic logic [31:0] forwardValue(input logic [4:0] src, input logic [31:0] raw);
        if (memRegWrite && src != 0 && src == memRd)
            return memAluResult;
        if (wbRegWrite && src != 0 && src == wbRd)
            return wbData;
        return raw;
    endfunction

    task automatic updateModel();
        aluOpE       op;
        logic        useShamt;
        logic [31:0] opA;
        logic [31:0] opB;
        if (rst)
        begin
            {expWb, expMem, expResult, expZero, expRegB, expDest} = '0;
        end
        else if (!stall)
        begin
            op = modelOp(exeCtrl[2:1], immExt[5:0], immOpcode);
            useShamt = exeCtrl[2:1] == MODE_RTYPE && immExt[10:6] != 0
                && (immExt[5:0] == FN_SLL || immExt[5:0] == FN_SRL || immExt[5:0] == FN_SRA);
            opA = useShamt ? {27'b0, immExt[10:6]} : forwardValue(rs, regA);
            opB = exeCtrl[0] ? immExt : forwardValue(rt, regB);
            expResult = modelAlu(op, opA, opB);
            expZero = expResult == 0;
            expWb = wbCtrl;
            expMem = memCtrl;
            expRegB = regB;
            expDest = exeCtrl[3] ? rd : rt;
        end
    endtask

    ////////////////////////////////////////
    // Checks and stimulus
    ////////////////////////////////////////
    task automatic checkValue(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            testErrors++;
            totalErrors++;
            $display("mismatch %s %s expected %h actual %h", testName, field, expected, actual);
        end
    endtask

    task automatic checkOutputs();
        checkValue("outWb", 32'(expWb), 32'(outWb));
        checkValue("outMem", 32'(expMem), 32'(outMem));
        checkValue("outAluResult", expResult, outAluResult);
        checkValue("outAluZero", 32'(expZero), 32'(outAluZero));
        checkValue("outRegB", expRegB, outRegB);
        checkValue("outDestReg", 32'(expDest), 32'(outDestReg));
        // Branch outputs from the raw inputs of this cycle
        checkValue("pcSel", 32'(memCtrl[2] && regA == regB), 32'(pcSel));
        checkValue("pcJump", pcNext + immExt, pcJump);
    endtask

    task automatic runVector(input int kind, input int index);
        logic [5:0]  fn;
        logic [4:0]  shamt;
        logic [1:0]  mode;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [15:0] half;
        logic [4:0]  s;
        logic [4:0]  t;
        logic [4:0]  mRd;
        logic [4:0]  wRd;
        logic        stallV;
        logic        rstV;
        a = randBits(32);
        b = randBits(32);
        imm = randBits(32);
        s = randBits(5);
        t = randBits(5);
        mRd = 0;
        wRd = 0;
        shamt = randBits(5);
        fn = rtypeList[randBits(8) % 7];
        mode = MODE_RTYPE;
        stallV = 0;
        rstV = 0;
        if (kind == 3 || kind == 4 || kind == 6)
            fn = randBits(1) ? shiftList[randBits(8) % 6] : rtypeList[randBits(8) % 7];
        if (kind == 3 && randBits(1))
            shamt = 0;
        // Small index range so that forwarding hits often
        if (kind == 4 || kind == 6)
        begin
            s = randBits(2);
            t = randBits(2);
            mRd = randBits(2);
            wRd = randBits(2);
        end
        if (kind == 2)
        begin
            mode = MODE_IMM;
            half = randBits(16);
            imm = {{16{half[15]}}, half};
        end
        else
        begin
            imm[10:0] = {shamt, fn};
        end
        if (kind == 5)
            mode = MODE_SUB;
        if ((kind == 1 || kind == 5) && randBits(2) < 2)
            b = a;
        if (kind == 6)
        begin
            stallV = randBits(2) == 0;
            if (index == 100)
            begin
                rstV = 1;
                stallV = 0;
            end
        end

        @(posedge clk);
        rst <= rstV;
        stall <= stallV;
        wbCtrl <= randBits(WB_W);
        memCtrl <= randBits(MEM_W);
        exeCtrl <= {kind != 2, mode, kind == 2};
        pcNext <= randBits(32);
        regA <= a;
        regB <= b;
        immExt <= imm;
        rs <= s;
        rt <= t;
        rd <= randBits(5);
        immOpcode <= immList[randBits(8) % 6];
        memAluResult <= randBits(32);
        memRd <= mRd;
        memRegWrite <= randBits(1);
        wbData <= randBits(32);
        wbRd <= wRd;
        wbRegWrite <= randBits(1);

        @(negedge clk);
        checkOutputs();
        updateModel();
    endtask

    task automatic runTest(input int kind, input string name);
        int i;
        testName = name;
        testErrors = 0;
        for (i = 0; i < vectorsPerTest; i++)
            runVector(kind, i);
        $display("test %-10s vectors %0d errors %0d", name, vectorsPerTest, testErrors);
    endtask

    initial
    begin
        lfsrState = 32'h32f7;
        totalErrors = 0;
        checkCount = 0;
        cycleCount = 0;
        clk = 0;
        rst = 1;
        stall = 0;
        {wbCtrl, memCtrl, exeCtrl, pcNext, regA, regB, immExt} = '0;
        {rs, rt, rd, immOpcode, memAluResult, memRd, memRegWrite} = '0;
        {wbData, wbRd, wbRegWrite} = '0;
        {expWb, expMem, expResult, expZero, expRegB, expDest} = '0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // The first edge after reset captures the idle inputs
        @(negedge clk);
        updateModel();

        runTest(1, "rtype");
        runTest(2, "immediate");
        runTest(3, "shift");
        runTest(4, "forwarding");
        runTest(5, "branch");
        runTest(6, "stallReset");

        $display("tests 6 checks %0d errors %0d", checkCount, totalErrors);
        if (totalErrors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/aluControl.sv
hw/forwardingUnit.sv
hw/operandSelect.sv
hw/alu.sv
hw/exMemRegister.sv
hw/executeStage.sv
testbench/tbExecuteStage.sv
